// File: Makefile
# Verilator build and run of the SCAD testbench

TOP := tbScad

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f filelist.f -o $(TOP)

# Fails when the log holds the fail message or the binary exits badly
run: compile
	./obj_dir/$(TOP) > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ]; then echo "Simulation exited with status $$status"; exit 1; fi
	@if grep -q "Checks failed" sim.log; then \
		echo "Simulation reported failure"; \
		exit 1; \
	fi
	@echo "Simulation finished without failure"

clean:
	rm -rf obj_dir sim.log

// File: filelist.f
scadPkg.sv
scadOperandSelect.sv
scadArith.sv
scadUnit.sv
tbScad.sv

// File: scadArith.sv
////////////////////
// SCAD arithmetic
// Eight-function ALU, SC and FE registers, negative dispatch
////////////////////

`default_nettype none
`timescale 1ns/1ps

module scadArith
   import scadPkg::*;
(
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 clkEn,
   input  logic [0:funWidth-1]  fun,
   input  logic [0:scadWidth-1] scadA,
   input  logic [0:scadWidth-1] scadB,
   input  logic                 loadSc,
   input  logic                 loadFe,
   output logic [0:scadWidth-1] scad,
   output logic [0:scadWidth-1] sc,
   output logic [0:scadWidth-1] fe,
   output logic [0:dispWidth-1] dispScad
);

   ////////////////////
   // ALU
   ////////////////////

   // Result wraps modulo 1024
   // Codes follow the microcode FUN field directly
   always_comb
   begin
      case (fun)
         funAPlusA:
            scad = scadA + scadA;
         funAOrB:
            scad = scadA | scadB;
         // Subtract with borrow in
         funAMinusBM1:
            scad = scadA - scadB - 1'b1;
         funAMinusB:
            scad = scadA - scadB;
         funAPlusB:
            scad = scadA + scadB;
         funAAndB:
            scad = scadA & scadB;
         // Decrement, used for step counting
         funAMinus1:
            scad = scadA - 1'b1;
         // Pass A through
         funA:
            scad = scadA;
      endcase
   end

   ////////////////////
   // Registers
   ////////////////////

   // Step count
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         sc <= '0;
      end
      else if (clkEn && loadSc)
      begin
         sc <= scad;
      end
   end

   // Floating exponent
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         fe <= '0;
      end
      else if (clkEn && loadFe)
      begin
         fe <= scad;
      end
   end

   ////////////////////
   // Dispatch
   ////////////////////

   // Bit 0 is the sign of the result
   assign dispScad = scad[0] ? dispNegative : {dispWidth{1'b0}};

   ////////////////////
   // Checks
   ////////////////////

   // SC only moves on an enabled load
   scHoldAssert: assert property (
      @(posedge clk) disable iff (rst)
      !(clkEn && loadSc) |=> $stable(sc)
   ) else $error("SC changed without clkEn and loadSc");

   // Same for FE
   feHoldAssert: assert property (
      @(posedge clk) disable iff (rst)
      !(clkEn && loadFe) |=> $stable(fe)
   ) else $error("FE changed without clkEn and loadFe");

endmodule

`default_nettype wire

// File: scadOperandSelect.sv
////////////////////
// SCAD operand select
// Builds the A and B operands from SC, FE, number field and data path
////////////////////

`default_nettype none
`timescale 1ns/1ps

module scadOperandSelect
   import scadPkg::*;
(
   input  logic [0:aselWidth-1] asel,
   input  logic [0:bselWidth-1] bsel,
   input  logic [0:numWidth-1]  num,
   input  logic [0:dpWidth-1]   dp,
   input  logic [0:scadWidth-1] sc,
   input  logic [0:scadWidth-1] fe,
   output logic [0:scadWidth-1] scadA,
   output logic [0:scadWidth-1] scadB
);

   // Data path word seen through both views
   dataWord_u dpWord;

   // Exponent magnitude of a float word
   logic [0:expWidth-1] expMag;

   // Size field of a byte pointer
   logic [0:sizeWidth-1] ptrSize;

   assign dpWord = dp;

   ////////////////////
   // Exponent
   ////////////////////

   // Negative floats hold a complemented exponent
   assign expMag = dpWord.floatView.sign ? ~dpWord.floatView.exponent
                                         : dpWord.floatView.exponent;

   assign ptrSize = dpWord.pointerView.size;

   ////////////////////
   // A mux
   ////////////////////

   // Odd bytes framed by num, even bytes by SC
   always_comb
   begin
      case (asel)
         aselSc:
            scadA = sc;
         aselNum:
            scadA = num;
         aselPtr44:
            scadA = {sc[0], ptrOctal44, dp[6], sc[8:9]};
         aselByte1:
            scadA = {num[0], dp[0:6], num[8:9]};
         aselByte2:
            scadA = {sc[0], dp[7:13], sc[8:9]};
         aselByte3:
            scadA = {num[0], dp[14:20], num[8:9]};
         aselByte4:
            scadA = {sc[0], dp[21:27], sc[8:9]};
         aselByte5:
            scadA = {num[0], dp[28:34], num[8:9]};
      endcase
   end

   ////////////////////
   // B mux
   ////////////////////

   always_comb
   begin
      case (bsel)
         bselFe:
            scadB = fe;
         bselExp:
            scadB = {2'b00, expMag};
         // Sign of the right half extended over the shift count
         bselShift:
            scadB = {dp[18], dp[18], dp[28:35]};
         // Size lands in bits 1 through 6
         bselSize:
            scadB = {1'b0, ptrSize, 3'b000};
      endcase
   end

   ////////////////////
   // Checks
   ////////////////////

   // Clean selects and sources give clean operands into the ALU
   always_comb
   begin
      if (!$isunknown({asel, bsel, num, dp, sc, fe}))
      begin
         operandKnownAssert: assert final (!$isunknown({scadA, scadB}))
            else $error("SCAD operand unknown with known inputs");
      end
   end

endmodule

`default_nettype wire

// File: scadPkg.sv
////////////////////
// SCAD package
// Microword layout, ALU and select codes, data path word views
////////////////////

`default_nettype none

package scadPkg;

   ////////////////////
   // Widths
   ////////////////////

   // SCAD result, SC, FE and both operands
   localparam int scadWidth  = 10;
   // Data path word
   localparam int dpWidth    = 36;
   // SCAD slice of the microword
   localparam int uWordWidth = 20;
   // Dispatch code
   localparam int dispWidth  = 4;

   // Float word fields
   localparam int expWidth   = 8;
   localparam int fracWidth  = 27;
   // Byte pointer fields
   localparam int posWidth   = 6;
   localparam int sizeWidth  = 6;
   localparam int restWidth  = 24;

   ////////////////////
   // Microword fields
   ////////////////////

   // First bit of each field, bit 0 is the MSB
   localparam int funPos     = 0;
   localparam int funWidth   = 3;
   localparam int aselPos    = 3;
   localparam int aselWidth  = 3;
   localparam int bselPos    = 6;
   localparam int bselWidth  = 2;
   localparam int numPos     = 8;
   localparam int numWidth   = 10;
   localparam int loadScPos  = 18;
   localparam int loadFePos  = 19;

   // ALU functions
   localparam logic [0:funWidth-1] funAPlusA     = 3'd0;
   localparam logic [0:funWidth-1] funAOrB       = 3'd1;
   localparam logic [0:funWidth-1] funAMinusBM1  = 3'd2;
   localparam logic [0:funWidth-1] funAMinusB    = 3'd3;
   localparam logic [0:funWidth-1] funAPlusB     = 3'd4;
   localparam logic [0:funWidth-1] funAAndB      = 3'd5;
   localparam logic [0:funWidth-1] funAMinus1    = 3'd6;
   localparam logic [0:funWidth-1] funA          = 3'd7;

   // A operand selects
   localparam logic [0:aselWidth-1] aselSc    = 3'd0;
   localparam logic [0:aselWidth-1] aselNum   = 3'd1;
   localparam logic [0:aselWidth-1] aselPtr44 = 3'd2;
   localparam logic [0:aselWidth-1] aselByte1 = 3'd3;
   localparam logic [0:aselWidth-1] aselByte2 = 3'd4;
   localparam logic [0:aselWidth-1] aselByte3 = 3'd5;
   localparam logic [0:aselWidth-1] aselByte4 = 3'd6;
   localparam logic [0:aselWidth-1] aselByte5 = 3'd7;

   // B operand selects
   localparam logic [0:bselWidth-1] bselFe    = 2'd0;
   localparam logic [0:bselWidth-1] bselExp   = 2'd1;
   localparam logic [0:bselWidth-1] bselShift = 2'd2;
   localparam logic [0:bselWidth-1] bselSize  = 2'd3;

   // Octal 44 middle of the pointer select
   localparam logic [0:5] ptrOctal44 = 6'o44;

   // Raised when SCAD bit 0 is set
   localparam logic [0:dispWidth-1] dispNegative = 4'b0010;

   ////////////////////
   // Data path word
   ////////////////////

   // One word, seen as a float or as a byte pointer
   typedef union packed {
      struct packed {
         logic                 sign;
         logic [0:expWidth-1]  exponent;
         logic [0:fracWidth-1] fraction;
      } floatView;
      struct packed {
         logic [0:posWidth-1]  position;
         logic [0:sizeWidth-1] size;
         logic [0:restWidth-1] rest;
      } pointerView;
   } dataWord_u;

endpackage

`default_nettype wire

// File: scadUnit.sv
////////////////////
// SCAD unit
// Splits the SCAD microword and joins operand select with the ALU
////////////////////

`default_nettype none
`timescale 1ns/1ps

module scadUnit
   import scadPkg::*;
(
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  clkEn,
   input  logic [0:uWordWidth-1] uWord,
   input  logic [0:dpWidth-1]    dp,
   output logic [0:scadWidth-1]  scad,
   output logic [0:scadWidth-1]  sc,
   output logic [0:scadWidth-1]  fe,
   output logic [0:dispWidth-1]  dispScad
);

   ////////////////////
   // Microword fields
   ////////////////////

   logic [0:funWidth-1]  fun;
   logic [0:aselWidth-1] asel;
   logic [0:bselWidth-1] bsel;
   logic [0:numWidth-1]  num;
   logic                 loadSc;
   logic                 loadFe;

   assign fun    = uWord[funPos  +: funWidth];
   assign asel   = uWord[aselPos +: aselWidth];
   assign bsel   = uWord[bselPos +: bselWidth];
   assign num    = uWord[numPos  +: numWidth];
   assign loadSc = uWord[loadScPos];
   assign loadFe = uWord[loadFePos];

   // Operands between the two halves
   logic [0:scadWidth-1] scadA;
   logic [0:scadWidth-1] scadB;

   // SC and FE loop back into the muxes
   scadOperandSelect uSelect (
      .asel  (asel),
      .bsel  (bsel),
      .num   (num),
      .dp    (dp),
      .sc    (sc),
      .fe    (fe),
      .scadA (scadA),
      .scadB (scadB)
   );

   scadArith uArith (
      .clk      (clk),
      .rst      (rst),
      .clkEn    (clkEn),
      .fun      (fun),
      .scadA    (scadA),
      .scadB    (scadB),
      .loadSc   (loadSc),
      .loadFe   (loadFe),
      .scad     (scad),
      .sc       (sc),
      .fe       (fe),
      .dispScad (dispScad)
   );

endmodule

`default_nettype wire

// File: tbScad.sv
////////////////////
// SCAD testbench
// Random operations checked against a reference model of the SCAD tables
////////////////////

`default_nettype none
`timescale 1ns/1ps

module tbScad
   import scadPkg::*;
();

   localparam int clkPeriod     = 20;
   localparam int numTests      = 6;
   localparam int cyclesPerTest = 300;

   logic                  clk;
   logic                  rst;
   logic                  clkEn;
   logic [0:uWordWidth-1] uWord;
   logic [0:dpWidth-1]    dp;
   logic [0:scadWidth-1]  scad;
   logic [0:scadWidth-1]  sc;
   logic [0:scadWidth-1]  fe;
   logic [0:dispWidth-1]  dispScad;

   // Model copies of SC and FE
   logic [0:scadWidth-1] modelSc;
   logic [0:scadWidth-1] modelFe;

   logic [31:0] lcgState = 32'h585b;
   int          passCount;
   int          failCount;
   int          testCheckStart;
   int          testFailStart;
   event        checkDone;

   scadUnit UUT (
      .clk      (clk),
      .rst      (rst),
      .clkEn    (clkEn),
      .uWord    (uWord),
      .dp       (dp),
      .scad     (scad),
      .sc       (sc),
      .fe       (fe),
      .dispScad (dispScad)
   );

   // 20 ns clock
   initial
   begin
      clk = 1'b0;
      forever
      begin
         #(clkPeriod / 2) clk = ~clk;
      end
   end

   ////////////////////
   // Helpers
   ////////////////////

   // LCG step
   function automatic logic [31:0] nextRandom();
      lcgState = lcgState * 32'd1664525 + 32'd1013904223;
      return lcgState;
   endfunction

   // Upper LCG bits are the better ones
   function automatic logic [0:scadWidth-1] randomNum();
      logic [31:0] r;
      r = nextRandom();
      return r[29:20];
   endfunction

   // Three upper slices make one word
   function automatic logic [0:dpWidth-1] randomDp();
      logic [31:0] r0;
      logic [31:0] r1;
      logic [31:0] r2;
      r0 = nextRandom();
      r1 = nextRandom();
      r2 = nextRandom();
      return {r0[31:20], r1[31:20], r2[31:20]};
   endfunction

   // Expected SCAD from the operand and function tables
   function automatic logic [0:scadWidth-1] refScad(
      input logic [0:2]  f,
      input logic [0:2]  aSel,
      input logic [0:1]  bSel,
      input logic [0:9]  n,
      input logic [0:35] d,
      input logic [0:9]  scVal,
      input logic [0:9]  feVal
   );
      logic [0:9] a;
      logic [0:9] b;
      logic [0:7] expField;
      int         r;
      case (aSel)
         aselSc:    a = scVal;
         aselNum:   a = n;
         aselPtr44: a = {scVal[0], 6'o44, d[6], scVal[8:9]};
         aselByte1: a = {n[0], d[0:6], n[8:9]};
         aselByte2: a = {scVal[0], d[7:13], scVal[8:9]};
         aselByte3: a = {n[0], d[14:20], n[8:9]};
         aselByte4: a = {scVal[0], d[21:27], scVal[8:9]};
         default:   a = {n[0], d[28:34], n[8:9]};
      endcase
      // Magnitude of the exponent, complemented on negative words
      expField = d[0] ? ~d[1:8] : d[1:8];
      case (bSel)
         bselFe:    b = feVal;
         bselExp:   b = {2'b00, expField};
         bselShift: b = {d[18], d[18], d[28:35]};
         default:   b = {1'b0, d[6:11], 3'b000};
      endcase
      case (f)
         funAPlusA:    r = int'(a) * 2;
         funAOrB:      r = int'(a | b);
         funAMinusBM1: r = int'(a) - int'(b) - 1;
         funAMinusB:   r = int'(a) - int'(b);
         funAPlusB:    r = int'(a) + int'(b);
         funAAndB:     r = int'(a & b);
         funAMinus1:   r = int'(a) - 1;
         default:      r = int'(a);
      endcase
      // Two's complement low bits give modulo 1024
      return r[9:0];
   endfunction

   task automatic reportError(
      input string      name,
      input logic [0:9] expVal,
      input logic [0:9] actVal
   );
      $display("** Error at %0d ns: %s expected %h, actual %h", $time, name, expVal, actVal);
      failCount++;
   endtask

   // One microword per cycle, 2 ns after the edge
   task automatic driveOp(
      input logic [0:2]  f,
      input logic [0:2]  aSel,
      input logic [0:1]  bSel,
      input logic [0:9]  n,
      input logic        ldSc,
      input logic        ldFe,
      input logic        en,
      input logic [0:35] d
   );
      @(posedge clk);
      #2;
      uWord = {f, aSel, bSel, n, ldSc, ldFe};
      clkEn = en;
      dp    = d;
   endtask

   // Waits for the last cycle's compare, then reports
   task automatic finishTest(input string name);
      @(checkDone);
      $display("Test %s done: %0d checks, %0d errors", name,
               passCount + failCount - testCheckStart, failCount - testFailStart);
      testCheckStart = passCount + failCount;
      testFailStart  = failCount;
   endtask

   ////////////////////
   // Compare
   ////////////////////

   // Runs 3 ns before each rising edge
   initial
   begin : compare
      logic [0:scadWidth-1] expScad;
      logic [0:dispWidth-1] expDisp;
      forever
      begin
         @(posedge clk);
         #(clkPeriod - 3);
         if (rst)
         begin
            modelSc = '0;
            modelFe = '0;
         end
         expScad = refScad(uWord[funPos +: funWidth], uWord[aselPos +: aselWidth],
                           uWord[bselPos +: bselWidth], uWord[numPos +: numWidth],
                           dp, modelSc, modelFe);
         expDisp = expScad[0] ? 4'b0010 : 4'b0000;
         if (scad !== expScad)
            reportError("scad", expScad, scad);
         else
            passCount++;
         if (sc !== modelSc)
            reportError("sc", modelSc, sc);
         else
            passCount++;
         if (fe !== modelFe)
            reportError("fe", modelFe, fe);
         else
            passCount++;
         if (dispScad !== expDisp)
            reportError("dispScad", {6'b0, expDisp}, {6'b0, dispScad});
         else
            passCount++;
         // Next model state as of the coming edge
         if (!rst && clkEn && uWord[loadScPos])
            modelSc = expScad;
         if (!rst && clkEn && uWord[loadFePos])
            modelFe = expScad;
         -> checkDone;
      end
   end

   ////////////////////
   // Stimulus
   ////////////////////

   initial
   begin : stimulus
      dataWord_u   w;
      logic [31:0] r;
      int          i;
      int          k;
      rst            = 1'b1;
      clkEn          = 1'b0;
      dp             = '0;
      uWord          = {funA, aselSc, bselFe, 10'd0, 1'b0, 1'b0};
      passCount      = 0;
      failCount      = 0;
      testCheckStart = 0;
      testFailStart  = 0;

      // Reset for 2 cycles, then SC passed through
      repeat (2) @(posedge clk);
      #2;
      rst = 1'b0;
      for (i = 0; i < 4; i++)
         driveOp(funA, aselSc, bselFe, 10'd0, 1'b0, 1'b0, 1'b1, randomDp());
      finishTest("reset");

      // Each function with num as A and FE as B
      for (k = 0; k < 8; k++)
      begin
         driveOp(funA, aselNum, bselFe, randomNum(), 1'b0, 1'b1, 1'b1, randomDp());
         // Zero A forces the wrap on subtraction
         driveOp(3'(k), aselNum, bselFe, 10'd0, 1'b0, 1'b0, 1'b1, randomDp());
         for (i = 0; i < 6; i++)
            driveOp(3'(k), aselNum, bselFe, randomNum(), 1'b0, 1'b0, 1'b1, randomDp());
      end
      finishTest("functions");

      // Each A arrangement after a random SC
      for (k = 0; k < 8; k++)
      begin
         driveOp(funA, aselNum, bselFe, randomNum(), 1'b1, 1'b0, 1'b1, randomDp());
         for (i = 0; i < 6; i++)
            driveOp(funA, 3'(k), bselFe, randomNum(), 1'b0, 1'b0, 1'b1, randomDp());
      end
      finishTest("aSelects");

      // B alone through OR with a zero A
      for (k = 0; k < 4; k++)
      begin
         for (i = 0; i < 8; i++)
         begin
            w = randomDp();
            // Alternate positive and negative floats
            w.floatView.sign = i[0];
            if (i >= 4)
               w.pointerView.size = 6'(i * 11);
            driveOp(funAOrB, aselNum, 2'(k), 10'd0, 1'b0, 1'b0, 1'b1, w);
         end
      end
      finishTest("bSelects");

      // Random loads and enables
      for (i = 0; i < 200; i++)
      begin
         r = nextRandom();
         driveOp(r[31:29], r[28:26], r[25:24], randomNum(), r[23], r[22], r[21], randomDp());
      end
      finishTest("loads");

      // Random operations for the sign dispatch
      for (i = 0; i < 120; i++)
      begin
         r = nextRandom();
         driveOp(r[31:29], r[28:26], r[25:24], randomNum(), r[23], r[22], 1'b1, randomDp());
      end
      finishTest("dispatch");

      $display("Totals: %0d passed, %0d failed", passCount, failCount);
      if (failCount == 0)
         $display("All checks passed");
      else
         $display("Checks failed");
      $finish;
   end

   // Watchdog
   initial
   begin
      #(numTests * cyclesPerTest * clkPeriod * 2);
      $display("Timeout: the tests did not complete within the watchdog limit");
      $display("Checks failed");
      $finish;
   end

endmodule

`default_nettype wire
